/* hdl/rename_pkg.sv */
package rename_pkg;

    localparam int ARCH_REGS    = 32;
    localparam int ARCH_IDX_W   = 5;
    localparam int PHYS_REGS    = 64;
    localparam int PHYS_IDX_W   = 6;
    localparam int ROB_DEPTH    = 32;
    localparam int ROB_IDX_W    = 5;
    // physical registers left over once every architectural register is mapped
    localparam int FREE_DEPTH   = 32;
    localparam int RETIRE_WIDTH = 2;

    // a dest of zero means no destination, whatever has_dest says
    typedef struct packed {
        logic                  valid;
        logic [ARCH_IDX_W-1:0] rs1;
        logic [ARCH_IDX_W-1:0] rs2;
        logic [ARCH_IDX_W-1:0] dest;
        logic                  has_dest;
    } rename_req_t;

    typedef struct packed {
        logic                  valid;
        logic [ROB_IDX_W-1:0]  rob_id;
        logic [PHYS_IDX_W-1:0] prs1;
        logic [PHYS_IDX_W-1:0] prs2;
        logic                  prs1_ready;
        logic                  prs2_ready;
        logic                  has_dest;
        logic [PHYS_IDX_W-1:0] pdest;
        logic [PHYS_IDX_W-1:0] old_pdest;
    } renamed_t;

    typedef struct packed {
        logic                  valid;
        logic [ROB_IDX_W-1:0]  rob_id;
        logic                  has_dest;
        logic [PHYS_IDX_W-1:0] pdest;
    } complete_t;

    typedef struct packed {
        logic                  done;
        logic [ARCH_IDX_W-1:0] arch_dest;
        logic                  has_dest;
        logic [PHYS_IDX_W-1:0] pdest;
        logic [PHYS_IDX_W-1:0] old_pdest;
    } rob_entry_t;

    typedef struct packed {
        logic                  valid;
        logic [ARCH_IDX_W-1:0] arch_dest;
        logic                  has_dest;
        logic [PHYS_IDX_W-1:0] pdest;
        logic [PHYS_IDX_W-1:0] old_pdest;
    } rob_alloc_t;

    typedef struct packed {
        logic                  valid;
        logic [ROB_IDX_W-1:0]  rob_id;
        logic [ARCH_IDX_W-1:0] arch_dest;
        logic                  has_dest;
        logic [PHYS_IDX_W-1:0] pdest;
        logic [PHYS_IDX_W-1:0] old_pdest;
    } commit_slot_t;

    // slot0 is always the older instruction
    typedef struct packed {
        commit_slot_t slot0;
        commit_slot_t slot1;
    } commit_pair_t;

    typedef struct packed {
        logic                  valid0;
        logic [PHYS_IDX_W-1:0] preg0;
        logic                  valid1;
        logic [PHYS_IDX_W-1:0] preg1;
    } release_t;

endpackage

/* hdl/rename_map.sv */
`timescale 1ns/1ps

module rename_map import rename_pkg::*; (
    input  logic                  cpu_clock_i,
    input  logic                  rst_i,
    input  rename_req_t           rename_req_i,
    input  complete_t             complete_i,
    input  logic [PHYS_IDX_W-1:0] free_preg_i,
    input  logic                  free_empty_i,
    output logic                  free_pop_o,
    input  logic [ROB_IDX_W-1:0]  rob_tail_i,
    input  logic                  rob_full_i,
    output rob_alloc_t            rob_alloc_o,
    output logic                  rename_busy_o,
    output renamed_t              rename_out_o
);

    typedef logic [PHYS_IDX_W-1:0] preg_t;

    preg_t                map_q [ARCH_REGS];
    logic [PHYS_REGS-1:0] busy_q;

    logic     accept;
    logic     dest_valid;
    preg_t    prs1;
    preg_t    prs2;
    preg_t    old_pdest;
    logic     wb_hit1;
    logic     wb_hit2;
    renamed_t rename_d;
    renamed_t rename_q;

    // stall even without a destination, keeps the source logic simple
    assign rename_busy_o = free_empty_i | rob_full_i;
    assign accept        = rename_req_i.valid & ~rename_busy_o;
    assign dest_valid    = rename_req_i.has_dest & (rename_req_i.dest != '0);
    assign free_pop_o    = accept & dest_valid;

    // lookups see the map before this instruction's own update
    assign prs1      = map_q[rename_req_i.rs1];
    assign prs2      = map_q[rename_req_i.rs2];
    assign old_pdest = map_q[rename_req_i.dest];

    // completion in this cycle counts as ready
    assign wb_hit1 = complete_i.valid & complete_i.has_dest & (complete_i.pdest == prs1);
    assign wb_hit2 = complete_i.valid & complete_i.has_dest & (complete_i.pdest == prs2);

    always_comb begin
        rename_d.valid      = accept;
        rename_d.rob_id     = rob_tail_i;
        rename_d.prs1       = prs1;
        rename_d.prs2       = prs2;
        rename_d.prs1_ready = ~busy_q[prs1] | wb_hit1;
        rename_d.prs2_ready = ~busy_q[prs2] | wb_hit2;
        rename_d.has_dest   = dest_valid;
        rename_d.pdest      = dest_valid ? free_preg_i : '0;
        rename_d.old_pdest  = dest_valid ? old_pdest : '0;
    end

    always_comb begin
        rob_alloc_o.valid     = accept;
        rob_alloc_o.arch_dest = dest_valid ? rename_req_i.dest : '0;
        rob_alloc_o.has_dest  = dest_valid;
        rob_alloc_o.pdest     = rename_d.pdest;
        rob_alloc_o.old_pdest = rename_d.old_pdest;
    end

    always_ff @(posedge cpu_clock_i) begin
        if (rst_i) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= preg_t'(i);
            end
            busy_q <= '0;
        end else begin
            if (complete_i.valid && complete_i.has_dest) begin
                busy_q[complete_i.pdest] <= 1'b0;
            end
            // the new preg is not in flight, so it never collides with the clear
            if (free_pop_o) begin
                map_q[rename_req_i.dest] <= free_preg_i;
                busy_q[free_preg_i]      <= 1'b1;
            end
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (rst_i) begin
            rename_q.valid <= 1'b0;
        end else if (accept) begin
            rename_q <= rename_d;
        end else begin
            rename_q.valid <= 1'b0;
        end
    end

    assign rename_out_o = rename_q;

endmodule

/* hdl/free_list.sv */
`timescale 1ns/1ps

module free_list import rename_pkg::*; (
    input  logic                  cpu_clock_i,
    input  logic                  rst_i,
    input  logic                  pop_i,
    output logic [PHYS_IDX_W-1:0] head_o,
    output logic                  empty_o,
    input  release_t              release_i
);

    typedef logic [$clog2(FREE_DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(FREE_DEPTH+1)-1:0] count_t;

    logic [PHYS_IDX_W-1:0] slots_q [FREE_DEPTH];
    ptr_t                  rd_ptr_q;
    ptr_t                  wr_ptr_q;
    ptr_t                  wr_ptr1;
    count_t                count_q;
    count_t                push_n;

    assign head_o  = slots_q[rd_ptr_q];
    assign empty_o = (count_q == '0);

    // slot 1 lands right behind slot 0 when both release
    assign wr_ptr1 = wr_ptr_q + ptr_t'(release_i.valid0);
    assign push_n  = count_t'(release_i.valid0) + count_t'(release_i.valid1);

    always_ff @(posedge cpu_clock_i) begin
        if (rst_i) begin
            // everything above the identity map starts out free
            for (int i = 0; i < FREE_DEPTH; i++) begin
                slots_q[i] <= PHYS_IDX_W'(ARCH_REGS + i);
            end
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= count_t'(FREE_DEPTH);
        end else begin
            if (release_i.valid0) begin
                slots_q[wr_ptr_q] <= release_i.preg0;
            end
            if (release_i.valid1) begin
                slots_q[wr_ptr1] <= release_i.preg1;
            end
            wr_ptr_q <= wr_ptr_q + ptr_t'(push_n);
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + ptr_t'(1);
            end
            count_q <= count_q + push_n - count_t'(pop_i);
        end
    end

endmodule

/* hdl/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer import rename_pkg::*; (
    input  logic                    cpu_clock_i,
    input  logic                    rst_i,
    input  rob_alloc_t              alloc_i,
    output logic [ROB_IDX_W-1:0]    tail_o,
    output logic                    full_o,
    input  complete_t               complete_i,
    output rob_entry_t              head_entry0_o,
    output rob_entry_t              head_entry1_o,
    output logic [RETIRE_WIDTH-1:0] head_valid_o,
    output logic [ROB_IDX_W-1:0]    head_id_o,
    input  logic [1:0]              retire_count_i
);

    typedef logic [ROB_IDX_W-1:0] idx_t;
    typedef logic [ROB_IDX_W:0]   count_t;

    rob_entry_t entries_q [ROB_DEPTH];
    idx_t       head_q;
    idx_t       tail_q;
    count_t     count_q;

    assign tail_o    = tail_q;
    assign full_o    = (count_q == count_t'(ROB_DEPTH));
    assign head_id_o = head_q;

    // two oldest entries, qualified by occupancy
    assign head_entry0_o   = entries_q[head_q];
    assign head_entry1_o   = entries_q[head_q + idx_t'(1)];
    assign head_valid_o[0] = (count_q != '0);
    assign head_valid_o[1] = (count_q > count_t'(1));

    always_ff @(posedge cpu_clock_i) begin
        if (alloc_i.valid) begin
            entries_q[tail_q].done      <= 1'b0;
            entries_q[tail_q].arch_dest <= alloc_i.arch_dest;
            entries_q[tail_q].has_dest  <= alloc_i.has_dest;
            entries_q[tail_q].pdest     <= alloc_i.pdest;
            entries_q[tail_q].old_pdest <= alloc_i.old_pdest;
        end
        // completions only name in-flight entries, never the tail slot
        if (complete_i.valid) begin
            entries_q[complete_i.rob_id].done <= 1'b1;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (rst_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_i.valid) begin
                tail_q <= tail_q + idx_t'(1);
            end
            head_q  <= head_q + idx_t'(retire_count_i);
            count_q <= count_q + count_t'(alloc_i.valid) - count_t'(retire_count_i);
        end
    end

endmodule

/* hdl/retire_unit.sv */
`timescale 1ns/1ps

module retire_unit import rename_pkg::*; (
    input  logic                    cpu_clock_i,
    input  logic                    rst_i,
    input  rob_entry_t              head_entry0_i,
    input  rob_entry_t              head_entry1_i,
    input  logic [RETIRE_WIDTH-1:0] head_valid_i,
    input  logic [ROB_IDX_W-1:0]    head_id_i,
    output logic [1:0]              retire_count_o,
    output release_t                release_o,
    output commit_pair_t            commit_o
);

    typedef logic [ROB_IDX_W-1:0] idx_t;

    logic         take0;
    logic         take1;
    commit_pair_t commit_d;
    commit_pair_t commit_q;

    function automatic commit_slot_t make_slot(logic take, idx_t id, rob_entry_t entry);
        commit_slot_t slot;
        slot.valid     = take;
        slot.rob_id    = id;
        slot.arch_dest = entry.arch_dest;
        slot.has_dest  = entry.has_dest;
        slot.pdest     = entry.pdest;
        slot.old_pdest = entry.old_pdest;
        return slot;
    endfunction

    // in order, the second entry only goes along with the first
    assign take0          = head_valid_i[0] & head_entry0_i.done;
    assign take1          = take0 & head_valid_i[1] & head_entry1_i.done;
    assign retire_count_o = {take1, take0 & ~take1};

    always_comb begin
        release_o.valid0 = take0 & head_entry0_i.has_dest;
        release_o.preg0  = head_entry0_i.old_pdest;
        release_o.valid1 = take1 & head_entry1_i.has_dest;
        release_o.preg1  = head_entry1_i.old_pdest;
    end

    always_comb begin
        commit_d.slot0 = make_slot(take0, head_id_i, head_entry0_i);
        commit_d.slot1 = make_slot(take1, head_id_i + idx_t'(1), head_entry1_i);
    end

    // report trails the decision by one cycle
    always_ff @(posedge cpu_clock_i) begin
        if (rst_i) begin
            commit_q.slot0.valid <= 1'b0;
            commit_q.slot1.valid <= 1'b0;
        end else begin
            commit_q <= commit_d;
        end
    end

    assign commit_o = commit_q;

endmodule

/* hdl/rename_engine.sv */
`timescale 1ns/1ps

module rename_engine import rename_pkg::*; (
    input  logic         cpu_clock_i,
    input  logic         rst_i,
    input  rename_req_t  rename_req_i,
    input  complete_t    complete_i,
    output logic         rename_busy_o,
    output renamed_t     rename_out_o,
    output commit_pair_t commit_o
);

    logic [PHYS_IDX_W-1:0]   free_preg;
    logic                    free_empty;
    logic                    free_pop;
    logic [ROB_IDX_W-1:0]    rob_tail;
    logic                    rob_full;
    rob_alloc_t              rob_alloc;
    rob_entry_t              head_entry0;
    rob_entry_t              head_entry1;
    logic [RETIRE_WIDTH-1:0] head_valid;
    logic [ROB_IDX_W-1:0]    head_id;
    logic [1:0]              retire_count;
    release_t                release_pregs;

    rename_map u_rename_map (
        .cpu_clock_i   (cpu_clock_i),
        .rst_i         (rst_i),
        .rename_req_i  (rename_req_i),
        .complete_i    (complete_i),
        .free_preg_i   (free_preg),
        .free_empty_i  (free_empty),
        .free_pop_o    (free_pop),
        .rob_tail_i    (rob_tail),
        .rob_full_i    (rob_full),
        .rob_alloc_o   (rob_alloc),
        .rename_busy_o (rename_busy_o),
        .rename_out_o  (rename_out_o)
    );

    free_list u_free_list (
        .cpu_clock_i (cpu_clock_i),
        .rst_i       (rst_i),
        .pop_i       (free_pop),
        .head_o      (free_preg),
        .empty_o     (free_empty),
        .release_i   (release_pregs)
    );

    reorder_buffer u_reorder_buffer (
        .cpu_clock_i    (cpu_clock_i),
        .rst_i          (rst_i),
        .alloc_i        (rob_alloc),
        .tail_o         (rob_tail),
        .full_o         (rob_full),
        .complete_i     (complete_i),
        .head_entry0_o  (head_entry0),
        .head_entry1_o  (head_entry1),
        .head_valid_o   (head_valid),
        .head_id_o      (head_id),
        .retire_count_i (retire_count)
    );

    retire_unit u_retire_unit (
        .cpu_clock_i    (cpu_clock_i),
        .rst_i          (rst_i),
        .head_entry0_i  (head_entry0),
        .head_entry1_i  (head_entry1),
        .head_valid_i   (head_valid),
        .head_id_i      (head_id),
        .retire_count_o (retire_count),
        .release_o      (release_pregs),
        .commit_o       (commit_o)
    );

endmodule

/* verification/rename_checker.sv */
`timescale 1ns/1ps

module rename_checker import rename_pkg::*; (
    input  logic         cpu_clock_i,
    input  logic         rst_i,
    input  rename_req_t  rename_req_i,
    input  complete_t    complete_i,
    input  logic         rename_busy_i,
    input  renamed_t     rename_out_i,
    input  commit_pair_t commit_i,
    output int           check_count_o,
    output int           error_count_o
);

    typedef logic [PHYS_IDX_W-1:0] preg_t;

    preg_t        map_m [ARCH_REGS];
    logic         busy_m [PHYS_REGS];
    preg_t        free_m [$];
    rob_entry_t   rob_m [ROB_DEPTH];
    int           rob_head;
    int           rob_tail;
    int           rob_count;
    renamed_t     exp_rename;
    commit_pair_t exp_commit;
    int           checks = 0;
    int           errors = 0;

    assign check_count_o = checks;
    assign error_count_o = errors;

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Error %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    function automatic logic written_back(input preg_t preg);
        return complete_i.valid && complete_i.has_dest && (complete_i.pdest == preg);
    endfunction

    function automatic commit_slot_t expected_slot(input logic take, input int idx);
        commit_slot_t s;
        s           = '0;
        s.valid     = take;
        s.rob_id    = ROB_IDX_W'(idx);
        s.arch_dest = rob_m[idx].arch_dest;
        s.has_dest  = rob_m[idx].has_dest;
        s.pdest     = rob_m[idx].pdest;
        s.old_pdest = rob_m[idx].old_pdest;
        return s;
    endfunction

    task automatic reset_model();
        free_m.delete();
        for (int i = 0; i < ARCH_REGS; i++) begin
            map_m[i] = preg_t'(i);
            free_m.push_back(preg_t'(ARCH_REGS + i));
        end
        for (int i = 0; i < PHYS_REGS; i++) begin
            busy_m[i] = 1'b0;
        end
        for (int i = 0; i < ROB_DEPTH; i++) begin
            rob_m[i] = '0;
        end
        rob_head   = 0;
        rob_tail   = 0;
        rob_count  = 0;
        exp_rename = '0;
        exp_commit = '0;
    endtask

    task automatic check_rename();
        check("rename valid", 32'(exp_rename.valid), 32'(rename_out_i.valid));
        if (exp_rename.valid && rename_out_i.valid) begin
            check("rename rob_id", 32'(exp_rename.rob_id), 32'(rename_out_i.rob_id));
            check("rename prs1", 32'(exp_rename.prs1), 32'(rename_out_i.prs1));
            check("rename prs2", 32'(exp_rename.prs2), 32'(rename_out_i.prs2));
            check("rename prs1_ready", 32'(exp_rename.prs1_ready), 32'(rename_out_i.prs1_ready));
            check("rename prs2_ready", 32'(exp_rename.prs2_ready), 32'(rename_out_i.prs2_ready));
            check("rename has_dest", 32'(exp_rename.has_dest), 32'(rename_out_i.has_dest));
            if (exp_rename.has_dest) begin
                check("rename pdest", 32'(exp_rename.pdest), 32'(rename_out_i.pdest));
                check("rename old_pdest", 32'(exp_rename.old_pdest), 32'(rename_out_i.old_pdest));
            end
        end
    endtask

    task automatic check_slot(input string slot, input commit_slot_t exp_s,
                              input commit_slot_t act_s);
        check({slot, " valid"}, 32'(exp_s.valid), 32'(act_s.valid));
        if (exp_s.valid && act_s.valid) begin
            check({slot, " rob_id"}, 32'(exp_s.rob_id), 32'(act_s.rob_id));
            check({slot, " has_dest"}, 32'(exp_s.has_dest), 32'(act_s.has_dest));
            if (exp_s.has_dest) begin
                check({slot, " arch_dest"}, 32'(exp_s.arch_dest), 32'(act_s.arch_dest));
                check({slot, " pdest"}, 32'(exp_s.pdest), 32'(act_s.pdest));
                check({slot, " old_pdest"}, 32'(exp_s.old_pdest), 32'(act_s.old_pdest));
            end
        end
    endtask

    // applies what the coming rising edge does to the engine state
    task automatic model_cycle();
        logic       model_busy;
        logic       accept;
        logic       dest_valid;
        logic       take0;
        logic       take1;
        int         retired;
        preg_t      prs1;
        preg_t      prs2;
        rob_entry_t entry;
        model_busy = (free_m.size() == 0) || (rob_count == ROB_DEPTH);
        check("rename busy", 32'(model_busy), 32'(rename_busy_i));
        // retire sees done bits from before this edge
        take0 = (rob_count > 0) && rob_m[rob_head].done;
        take1 = take0 && (rob_count > 1) && rob_m[(rob_head + 1) % ROB_DEPTH].done;
        exp_commit.slot0 = expected_slot(take0, rob_head);
        exp_commit.slot1 = expected_slot(take1, (rob_head + 1) % ROB_DEPTH);
        accept     = rename_req_i.valid && !model_busy;
        dest_valid = rename_req_i.has_dest && (rename_req_i.dest != '0);
        exp_rename = '0;
        entry      = '0;
        if (accept) begin
            prs1 = map_m[rename_req_i.rs1];
            prs2 = map_m[rename_req_i.rs2];
            exp_rename.valid      = 1'b1;
            exp_rename.rob_id     = ROB_IDX_W'(rob_tail);
            exp_rename.prs1       = prs1;
            exp_rename.prs2       = prs2;
            exp_rename.prs1_ready = !busy_m[prs1] || written_back(prs1);
            exp_rename.prs2_ready = !busy_m[prs2] || written_back(prs2);
            exp_rename.has_dest   = dest_valid;
            entry.has_dest        = dest_valid;
            if (dest_valid) begin
                exp_rename.pdest         = free_m.pop_front();
                exp_rename.old_pdest     = map_m[rename_req_i.dest];
                map_m[rename_req_i.dest] = exp_rename.pdest;
                entry.arch_dest          = rename_req_i.dest;
                entry.pdest              = exp_rename.pdest;
                entry.old_pdest          = exp_rename.old_pdest;
            end
        end
        if (complete_i.valid) begin
            if (((int'(complete_i.rob_id) - rob_head + ROB_DEPTH) % ROB_DEPTH) >= rob_count) begin
                errors++;
                $display("Completion names entry %0d, which is not in flight", complete_i.rob_id);
            end
            rob_m[complete_i.rob_id].done = 1'b1;
            if (complete_i.has_dest) begin
                busy_m[complete_i.pdest] = 1'b0;
            end
        end
        if (accept) begin
            if (dest_valid) begin
                busy_m[exp_rename.pdest] = 1'b1;
            end
            rob_m[rob_tail] = entry;
            rob_tail        = (rob_tail + 1) % ROB_DEPTH;
        end
        // old pregs rejoin the free list in slot order
        if (take0 && exp_commit.slot0.has_dest) begin
            free_m.push_back(exp_commit.slot0.old_pdest);
        end
        if (take1 && exp_commit.slot1.has_dest) begin
            free_m.push_back(exp_commit.slot1.old_pdest);
        end
        retired   = int'(take0) + int'(take1);
        rob_head  = (rob_head + retired) % ROB_DEPTH;
        rob_count = rob_count + int'(accept) - retired;
    endtask

    // mid-cycle, inputs and registered outputs are both settled
    always @(negedge cpu_clock_i) begin
        if (rst_i) begin
            reset_model();
        end else begin
            check_rename();
            check_slot("commit slot0", exp_commit.slot0, commit_i.slot0);
            check_slot("commit slot1", exp_commit.slot1, commit_i.slot1);
            model_cycle();
        end
    end

endmodule

/* verification/rename_tb.sv */
`timescale 1ns/1ps

module rename_tb import rename_pkg::*; ();

    logic         cpu_clock;
    logic         rst;
    rename_req_t  rename_req;
    complete_t    complete;
    logic         rename_busy;
    renamed_t     rename_out;
    commit_pair_t commit;

    integer    seed = 29;
    int        accepted;
    int        committed;
    int        stall_errors;
    int        timeouts;
    int        check_count;
    int        error_count;
    complete_t inflight [$];

    rename_engine dut_i (
        .cpu_clock_i   (cpu_clock),
        .rst_i         (rst),
        .rename_req_i  (rename_req),
        .complete_i    (complete),
        .rename_busy_o (rename_busy),
        .rename_out_o  (rename_out),
        .commit_o      (commit)
    );

    rename_checker u_checker (
        .cpu_clock_i   (cpu_clock),
        .rst_i         (rst),
        .rename_req_i  (rename_req),
        .complete_i    (complete),
        .rename_busy_i (rename_busy),
        .rename_out_i  (rename_out),
        .commit_i      (commit),
        .check_count_o (check_count),
        .error_count_o (error_count)
    );

    initial begin
        cpu_clock = 1'b0;
        forever #4 cpu_clock = ~cpu_clock;
    end

    // cpl_mode 0 holds completions back, 1 completes at random, 2 every cycle
    task automatic step(input bit want_req, input bit want_dest, input int cpl_mode,
                        output bit issued);
        complete_t entry;
        int        pick;
        @(posedge cpu_clock);
        #1;
        committed += int'(commit.slot0.valid) + int'(commit.slot1.valid);
        if (rename_out.valid) begin
            entry.valid    = 1'b1;
            entry.rob_id   = rename_out.rob_id;
            entry.has_dest = rename_out.has_dest;
            entry.pdest    = rename_out.pdest;
            inflight.push_back(entry);
        end
        complete = '0;
        if (inflight.size() > 0 &&
            (cpl_mode == 2 || (cpl_mode == 1 && ($random(seed) & 1) != 0))) begin
            pick     = int'($unsigned($random(seed)) % inflight.size());
            complete = inflight[pick];
            inflight.delete(pick);
        end
        rename_req = '0;
        issued     = 1'b0;
        if (want_req && !rename_busy) begin
            rename_req.valid    = 1'b1;
            rename_req.rs1      = ARCH_IDX_W'($random(seed));
            rename_req.rs2      = ARCH_IDX_W'($random(seed));
            rename_req.dest     = ARCH_IDX_W'($random(seed));
            rename_req.has_dest = want_dest || (($random(seed) & 7) != 0);
            if (want_dest && rename_req.dest == '0) begin
                rename_req.dest = ARCH_IDX_W'(1);
            end
            issued = 1'b1;
            accepted++;
        end
    endtask

    task automatic drain(input string phase);
        int cycles;
        bit issued;
        cycles = 0;
        while (committed != accepted && cycles < 500) begin
            step(1'b0, 1'b0, 2, issued);
            cycles++;
        end
        if (committed != accepted) begin
            timeouts++;
            $display("Timeout: the %s drain left accepted instructions uncommitted", phase);
        end
    endtask

    initial begin
        bit issued;
        bit saw_busy;
        int stress_count;
        int cycles;
        rst          = 1'b1;
        rename_req   = '0;
        complete     = '0;
        accepted     = 0;
        committed    = 0;
        stall_errors = 0;
        timeouts     = 0;
        repeat (4) @(posedge cpu_clock);
        #1;
        rst = 1'b0;

        repeat (400) begin
            step(($random(seed) & 3) != 0, 1'b0, 1, issued);
        end

        // no completions, so the engine has to run out of room
        stress_count = 0;
        cycles       = 0;
        saw_busy     = 1'b0;
        while (!saw_busy && cycles < 100) begin
            step(1'b1, 1'b0, 0, issued);
            stress_count += int'(issued);
            saw_busy = rename_busy;
            cycles++;
        end
        if (!saw_busy) begin
            timeouts++;
            $display("Timeout: rename_busy_o never rose during the stress phase");
        end else if (stress_count > 32) begin
            stall_errors++;
            $display("Error stress_stall: expected at most 32, actual %0d", stress_count);
        end
        repeat (8) begin
            step(1'b1, 1'b0, 0, issued);
        end

        drain("stress");
        for (int i = 0; i < 32; i++) begin
            step(1'b1, 1'b1, 0, issued);
            if (!issued) begin
                stall_errors++;
                $display("Rename stalled at request %0d of the recovery burst", i);
            end
        end
        drain("final");
        repeat (2) begin
            step(1'b0, 1'b0, 0, issued);
        end

        $display("checks %0d, errors %0d, stall errors %0d, timeouts %0d",
                 check_count, error_count, stall_errors, timeouts);
        if (error_count == 0 && stall_errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
hdl/rename_pkg.sv
hdl/rename_map.sv
hdl/free_list.sv
hdl/reorder_buffer.sv
hdl/retire_unit.sv
hdl/rename_engine.sv
verification/rename_checker.sv
verification/rename_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module rename_tb -f sources.f

out=$(./obj_dir/Vrename_tb)
echo "$out"

# grep fails the script when the pass line is missing
echo "$out" | grep -q "^TEST RESULT: PASS$"
